// ==== include/mips_defs.svh ====
// ##############################
// opcode, function code and memory-map macros
// included by the package and the decoder
// ##############################
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// primary opcodes
`define OP_RTYPE 6'h00
`define OP_J     6'h02
`define OP_BEQ   6'h04
`define OP_BNE   6'h05
`define OP_ADDI  6'h08
`define OP_ANDI  6'h0c
`define OP_ORI   6'h0d
`define OP_XORI  6'h0e
`define OP_LUI   6'h0f
`define OP_COP0  6'h10
`define OP_LB    6'h20
`define OP_SB    6'h28
`define OP_LD    6'h37
`define OP_SD    6'h3f

// r-type function codes
`define FN_SLL 6'h00
`define FN_SRL 6'h02
`define FN_SRA 6'h03
`define FN_JR  6'h08
`define FN_ADD 6'h20
`define FN_SUB 6'h22
`define FN_AND 6'h24
`define FN_OR  6'h25
`define FN_XOR 6'h26
`define FN_NOR 6'h27
`define FN_SLT 6'h2a

// coprocessor 0 rs field, eret function code
`define C0_MF   5'h00
`define C0_MT   5'h04
`define C0_CO   5'h10
`define FN_ERET 6'h18

// io addresses sit outside data memory, sign-extended so lui/ori can form them
`define MIPS_TIMER_ADDR   64'hFFFF_FFFF_FFFF_001C
`define MIPS_TIMER_ACK    64'hFFFF_FFFF_FFFF_006C
`define MIPS_HANDLER_ADDR 64'h0000_0000_0000_0200

`endif

// ==== src/mips_pkg.sv ====
// ##############################
// shared widths, types and constants for the
// single-cycle machine, used by scoped name
// ##############################
package mips_pkg;
    `include "mips_defs.svh"

    typedef logic [63:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_NOR = 3'd5
    } alu_op_e;

    typedef enum logic [1:0] {
        PC_SEQ    = 2'd0,
        PC_BRANCH = 2'd1,
        PC_JUMP   = 2'd2,
        PC_REG    = 2'd3
    } pc_src_e;

    typedef enum logic [1:0] {
        B_REG      = 2'd0,
        B_SIGN_IMM = 2'd1,
        B_ZERO_IMM = 2'd2
    } b_src_e;

    // decoder output, one bit per datapath control
    typedef struct packed {
        alu_op_e alu_op;
        b_src_e  b_src;
        pc_src_e pc_src;
        logic    reg_write;
        logic    rd_from_rt;
        logic    mem_read;
        logic    dword_we;
        logic    byte_we;
        logic    byte_load;
        logic    slt;
        logic    lui;
        logic    shift_sel;
        logic    shift_right;
        logic    shift_arith;
        logic    mfc0;
        logic    mtc0;
        logic    eret;
    } ctrl_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        word_t     data;
    } wb_t;

    localparam word_t TIMER_ADDR     = `MIPS_TIMER_ADDR;
    localparam word_t TIMER_ACK_ADDR = `MIPS_TIMER_ACK;
    localparam word_t HANDLER_ADDR   = `MIPS_HANDLER_ADDR;

    localparam int DMEM_WORDS = 512;

    localparam reg_addr_t CP0_STATUS = 5'd12;
    localparam reg_addr_t CP0_CAUSE  = 5'd13;
    localparam reg_addr_t CP0_EPC    = 5'd14;
endpackage

// ==== src/mips_decoder.sv ====
// ##############################
// instruction decoder, combinational
// anything outside the supported set raises except
// ##############################
`include "mips_defs.svh"

module mips_decoder (
    input  mips_pkg::inst_t inst,
    output mips_pkg::ctrl_t ctrl,
    output logic            except
);
    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] rs;

    assign opcode = inst[31:26];
    assign funct  = inst[5:0];
    assign rs     = inst[25:21];

    always_comb begin
        // all write enables off unless a legal encoding turns them on
        ctrl   = '0;
        except = 1'b0;
        case (opcode)
            `OP_RTYPE: begin
                ctrl.reg_write = 1'b1;
                case (funct)
                    `FN_ADD: ctrl.alu_op = mips_pkg::ALU_ADD;
                    `FN_SUB: ctrl.alu_op = mips_pkg::ALU_SUB;
                    `FN_AND: ctrl.alu_op = mips_pkg::ALU_AND;
                    `FN_OR:  ctrl.alu_op = mips_pkg::ALU_OR;
                    `FN_XOR: ctrl.alu_op = mips_pkg::ALU_XOR;
                    `FN_NOR: ctrl.alu_op = mips_pkg::ALU_NOR;
                    `FN_SLT: begin
                        ctrl.alu_op = mips_pkg::ALU_SUB;
                        ctrl.slt    = 1'b1;
                    end
                    `FN_SLL: ctrl.shift_sel = 1'b1;
                    `FN_SRL: begin
                        ctrl.shift_sel   = 1'b1;
                        ctrl.shift_right = 1'b1;
                    end
                    `FN_SRA: begin
                        ctrl.shift_sel   = 1'b1;
                        ctrl.shift_right = 1'b1;
                        ctrl.shift_arith = 1'b1;
                    end
                    `FN_JR: begin
                        ctrl.reg_write = 1'b0;
                        ctrl.pc_src    = mips_pkg::PC_REG;
                    end
                    default: begin
                        ctrl.reg_write = 1'b0;
                        except         = 1'b1;
                    end
                endcase
            end
            `OP_ADDI, `OP_ANDI, `OP_ORI, `OP_XORI: begin
                ctrl.reg_write  = 1'b1;
                ctrl.rd_from_rt = 1'b1;
                ctrl.b_src      = (opcode == `OP_ADDI) ? mips_pkg::B_SIGN_IMM
                                                       : mips_pkg::B_ZERO_IMM;
                case (opcode)
                    `OP_ANDI: ctrl.alu_op = mips_pkg::ALU_AND;
                    `OP_ORI:  ctrl.alu_op = mips_pkg::ALU_OR;
                    `OP_XORI: ctrl.alu_op = mips_pkg::ALU_XOR;
                    default:  ctrl.alu_op = mips_pkg::ALU_ADD;
                endcase
            end
            `OP_LUI: begin
                ctrl.reg_write  = 1'b1;
                ctrl.rd_from_rt = 1'b1;
                ctrl.lui        = 1'b1;
            end
            `OP_BEQ, `OP_BNE: begin
                ctrl.alu_op = mips_pkg::ALU_SUB;
                ctrl.pc_src = mips_pkg::PC_BRANCH;
            end
            `OP_J: ctrl.pc_src = mips_pkg::PC_JUMP;
            `OP_LD, `OP_LB: begin
                ctrl.b_src      = mips_pkg::B_SIGN_IMM;
                ctrl.reg_write  = 1'b1;
                ctrl.rd_from_rt = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.byte_load  = (opcode == `OP_LB);
            end
            `OP_SD, `OP_SB: begin
                ctrl.b_src    = mips_pkg::B_SIGN_IMM;
                ctrl.dword_we = (opcode == `OP_SD);
                ctrl.byte_we  = (opcode == `OP_SB);
            end
            `OP_COP0: begin
                if (rs == `C0_MF) begin
                    ctrl.reg_write  = 1'b1;
                    ctrl.rd_from_rt = 1'b1;
                    ctrl.mfc0       = 1'b1;
                end else if (rs == `C0_MT) begin
                    ctrl.mtc0 = 1'b1;
                end else if (rs == `C0_CO && funct == `FN_ERET) begin
                    ctrl.eret = 1'b1;
                end else begin
                    except = 1'b1;
                end
            end
            default: except = 1'b1;
        endcase
    end
endmodule

// ==== src/exec_unit.sv ====
// ##############################
// alu, shifter and result select
// result doubles as the data-memory address
// ##############################
module exec_unit (
    input  mips_pkg::word_t a,
    input  mips_pkg::word_t b,
    input  logic [15:0]     imm,
    input  logic [4:0]      shamt,
    input  mips_pkg::ctrl_t ctrl,
    output mips_pkg::word_t result,
    output logic            zero
);
    mips_pkg::word_t b_op;
    mips_pkg::word_t diff;
    mips_pkg::word_t alu_out;
    mips_pkg::word_t shift_out;
    mips_pkg::word_t lui_val;
    logic            less;

    always_comb begin
        case (ctrl.b_src)
            mips_pkg::B_SIGN_IMM: b_op = {{48{imm[15]}}, imm};
            mips_pkg::B_ZERO_IMM: b_op = {48'b0, imm};
            default:              b_op = b;
        endcase
    end

    assign diff = a - b_op;
    assign zero = (diff == '0);
    assign less = $signed(a) < $signed(b_op);

    always_comb begin
        case (ctrl.alu_op)
            mips_pkg::ALU_SUB: alu_out = diff;
            mips_pkg::ALU_AND: alu_out = a & b_op;
            mips_pkg::ALU_OR:  alu_out = a | b_op;
            mips_pkg::ALU_XOR: alu_out = a ^ b_op;
            mips_pkg::ALU_NOR: alu_out = ~(a | b_op);
            default:           alu_out = a + b_op;
        endcase
    end

    // shifts always act on rt, never on the immediate
    always_comb begin
        if (!ctrl.shift_right) begin
            shift_out = b << shamt;
        end else if (ctrl.shift_arith) begin
            shift_out = $unsigned($signed(b) >>> shamt);
        end else begin
            shift_out = b >> shamt;
        end
    end

    // upper half follows the immediate sign, as lui does on a 64-bit core
    assign lui_val = {{32{imm[15]}}, imm, 16'b0};

    always_comb begin
        if (ctrl.lui) begin
            result = lui_val;
        end else if (ctrl.shift_sel) begin
            result = shift_out;
        end else if (ctrl.slt) begin
            result = {63'b0, less};
        end else begin
            result = alu_out;
        end
    end
endmodule

// ==== src/regfile.sv ====
// ##############################
// 32 x 64-bit register file
// two async reads, one write per edge
// ##############################
module regfile (
    input  logic                clock,
    input  logic                arst_n,
    input  mips_pkg::reg_addr_t rs_addr,
    input  mips_pkg::reg_addr_t rt_addr,
    input  mips_pkg::reg_addr_t w_addr,
    input  mips_pkg::word_t     w_data,
    input  logic                w_en,
    output mips_pkg::word_t     rs_data,
    output mips_pkg::word_t     rt_data
);
    mips_pkg::word_t regs [32];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (w_en && w_addr != '0) begin
            regs[w_addr] <= w_data;
        end
    end

    // register zero reads as zero
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];
endmodule

// ==== src/data_mem.sv ====
// ##############################
// doubleword data memory with byte lanes
// async read, stores land on the clock edge
// ##############################
module data_mem (
    input  logic            clock,
    input  logic            arst_n,
    input  mips_pkg::word_t addr,
    input  mips_pkg::word_t w_data,
    input  logic            dword_we,
    input  logic            byte_we,
    input  logic            byte_load,
    output mips_pkg::word_t r_data
);
    mips_pkg::word_t                         mem [mips_pkg::DMEM_WORDS];
    logic [$clog2(mips_pkg::DMEM_WORDS)-1:0] idx;
    logic [2:0]                              lane;
    mips_pkg::word_t                         word;
    logic [7:0]                              lane_byte;

    assign idx  = addr[$clog2(mips_pkg::DMEM_WORDS)+2:3];
    assign lane = addr[2:0];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < mips_pkg::DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (dword_we) begin
            mem[idx] <= w_data;
        end else if (byte_we) begin
            mem[idx][lane*8 +: 8] <= w_data[7:0];
        end
    end

    // little-endian lane pick, then sign extend for lb
    assign word      = mem[idx];
    assign lane_byte = word[lane*8 +: 8];
    assign r_data    = byte_load ? {{56{lane_byte[7]}}, lane_byte} : word;
endmodule

// ==== src/timer.sv ====
// ##############################
// free-running cycle counter with compare irq
// irq holds until acknowledged
// ##############################
module timer (
    input  logic            clock,
    input  logic            arst_n,
    input  mips_pkg::word_t w_data,
    input  logic            cmp_we,
    input  logic            ack_we,
    output mips_pkg::word_t cycle,
    output logic            irq
);
    mips_pkg::word_t cmp;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            cycle <= '0;
            cmp   <= '1;
            irq   <= 1'b0;
        end else begin
            cycle <= cycle + 64'd1;
            if (cmp_we) begin
                cmp <= w_data;
            end
            // ack wins over a match on the same edge
            if (ack_we) begin
                irq <= 1'b0;
            end else if (cycle == cmp) begin
                irq <= 1'b1;
            end
        end
    end
endmodule

// ==== src/cp0.sv ====
// ##############################
// coprocessor 0: status, cause and epc
// decides when the timer interrupt is taken
// ##############################
module cp0 (
    input  logic                clock,
    input  logic                arst_n,
    input  mips_pkg::word_t     w_data,
    input  mips_pkg::reg_addr_t reg_sel,
    input  logic                mtc0,
    input  logic                eret,
    input  logic                irq,
    input  mips_pkg::word_t     next_pc,
    output mips_pkg::word_t     r_data,
    output mips_pkg::word_t     epc,
    output logic                taken_interrupt
);
    mips_pkg::word_t status;
    mips_pkg::word_t cause;

    // cause bit 15 mirrors the pending timer line
    assign cause = {48'b0, irq, 15'b0};

    // ie set, exl clear
    assign taken_interrupt = irq & status[0] & ~status[1];

    always_comb begin
        case (reg_sel)
            mips_pkg::CP0_STATUS: r_data = status;
            mips_pkg::CP0_CAUSE:  r_data = cause;
            mips_pkg::CP0_EPC:    r_data = epc;
            default:              r_data = '0;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            status <= '0;
            epc    <= '0;
        end else begin
            if (mtc0 && reg_sel == mips_pkg::CP0_STATUS) begin
                status <= w_data;
            end
            if (mtc0 && reg_sel == mips_pkg::CP0_EPC) begin
                epc <= w_data;
            end
            if (eret) begin
                status[1] <= 1'b0;
            end
            // taking the interrupt overrides any write above
            if (taken_interrupt) begin
                epc       <= next_pc;
                status[1] <= 1'b1;
            end
        end
    end
endmodule

// ==== src/full_machine.sv ====
// ##############################
// single-cycle 64-bit mips-style core
// fetch is external: pc out, inst in, same cycle
// ##############################
module full_machine (
    input  logic            clock,
    input  logic            arst_n,
    input  mips_pkg::inst_t inst,
    output mips_pkg::word_t pc,
    output mips_pkg::wb_t   wb,
    output logic            except
);
    mips_pkg::ctrl_t     ctrl;
    mips_pkg::word_t     rs_data;
    mips_pkg::word_t     rt_data;
    mips_pkg::word_t     result;
    mips_pkg::word_t     mem_data;
    mips_pkg::word_t     cycle;
    mips_pkg::word_t     cp0_data;
    mips_pkg::word_t     epc;
    mips_pkg::word_t     pc4;
    mips_pkg::word_t     branch_target;
    mips_pkg::word_t     jump_target;
    mips_pkg::word_t     next_pc;
    mips_pkg::reg_addr_t w_addr;
    logic                zero;
    logic                irq;
    logic                taken_interrupt;
    logic                timer_sel;
    logic                ack_sel;
    logic                branch_taken;

    mips_decoder u_decoder (.inst(inst), .ctrl(ctrl), .except(except));

    assign w_addr = ctrl.rd_from_rt ? inst[20:16] : inst[15:11];

    regfile u_regfile (
        .clock(clock), .arst_n(arst_n),
        .rs_addr(inst[25:21]), .rt_addr(inst[20:16]),
        .w_addr(w_addr), .w_data(wb.data), .w_en(wb.valid),
        .rs_data(rs_data), .rt_data(rt_data)
    );

    exec_unit u_exec (
        .a(rs_data), .b(rt_data), .imm(inst[15:0]), .shamt(inst[10:6]),
        .ctrl(ctrl), .result(result), .zero(zero)
    );

    // io stores are steered away from data memory
    assign timer_sel = (result == mips_pkg::TIMER_ADDR);
    assign ack_sel   = (result == mips_pkg::TIMER_ACK_ADDR);

    data_mem u_dmem (
        .clock(clock), .arst_n(arst_n), .addr(result), .w_data(rt_data),
        .dword_we(ctrl.dword_we & ~(timer_sel | ack_sel)),
        .byte_we(ctrl.byte_we & ~(timer_sel | ack_sel)),
        .byte_load(ctrl.byte_load), .r_data(mem_data)
    );

    timer u_timer (
        .clock(clock), .arst_n(arst_n), .w_data(rt_data),
        .cmp_we((ctrl.dword_we | ctrl.byte_we) & timer_sel),
        .ack_we((ctrl.dword_we | ctrl.byte_we) & ack_sel),
        .cycle(cycle), .irq(irq)
    );

    cp0 u_cp0 (
        .clock(clock), .arst_n(arst_n), .w_data(rt_data), .reg_sel(inst[15:11]),
        .mtc0(ctrl.mtc0), .eret(ctrl.eret), .irq(irq), .next_pc(next_pc),
        .r_data(cp0_data), .epc(epc), .taken_interrupt(taken_interrupt)
    );

    assign pc4           = pc + 64'd4;
    assign branch_target = pc4 + {{46{inst[15]}}, inst[15:0], 2'b00};
    assign jump_target   = {pc4[63:28], inst[25:0], 2'b00};
    // bne differs from beq only in opcode bit 0
    assign branch_taken  = zero ^ inst[26];

    always_comb begin
        case (ctrl.pc_src)
            mips_pkg::PC_BRANCH: next_pc = branch_taken ? branch_target : pc4;
            mips_pkg::PC_JUMP:   next_pc = jump_target;
            mips_pkg::PC_REG:    next_pc = rs_data;
            default:             next_pc = pc4;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (taken_interrupt) begin
            pc <= mips_pkg::HANDLER_ADDR;
        end else if (ctrl.eret) begin
            pc <= epc;
        end else begin
            pc <= next_pc;
        end
    end

    // writes to r0 are dropped, so they are not reported
    always_comb begin
        wb.valid = ctrl.reg_write & (w_addr != '0);
        wb.addr  = w_addr;
        if (ctrl.mfc0) begin
            wb.data = cp0_data;
        end else if (ctrl.mem_read) begin
            wb.data = timer_sel ? cycle : mem_data;
        end else begin
            wb.data = result;
        end
    end
endmodule

// ==== dv/tb_full_machine.sv ====
// ##############################
// testbench for full_machine, acts as the
// instruction cache and reads program and expected
// writebacks from dv/program_trace.txt
// ##############################
module tb_full_machine;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int IMEM_WORDS   = 1024;
    localparam int WAIT_CYCLES  = 200;
    localparam int RESET_CYCLES = 10;

    logic            clock;
    logic            arst_n;
    mips_pkg::inst_t inst;
    mips_pkg::word_t pc;
    mips_pkg::wb_t   wb;
    logic            except;

    mips_pkg::inst_t     imem [IMEM_WORDS];
    mips_pkg::reg_addr_t exp_addr [$];
    mips_pkg::word_t     exp_data [$];
    logic                except_expected;
    int                  seed;
    int                  idle_cycles;

    full_machine u_dut (
        .clock(clock), .arst_n(arst_n), .inst(inst),
        .pc(pc), .wb(wb), .except(except)
    );

    // fetch outside the array returns an illegal opcode
    assign inst = (pc[63:12] == '0) ? imem[pc[11:2]] : 32'hF800_0000;

    initial begin
        clock = 1'b0;
        forever begin
            #4 clock = ~clock;
        end
    end

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_wb(
        input mips_pkg::reg_addr_t got_addr,
        input mips_pkg::word_t     got_data,
        input mips_pkg::reg_addr_t want_addr,
        input mips_pkg::word_t     want_data
    );
        if (got_addr !== want_addr || got_data !== want_data) begin
            $display("** Error: time %0t: writeback r%0d = %h, expected r%0d = %h",
                     $time, got_addr, got_data, want_addr, want_data);
            abort_run();
        end
    endtask

    task automatic check_except(input logic got_except, input logic got_valid);
        if (got_except !== 1'b1 || got_valid !== 1'b0) begin
            $display("** Error: time %0t: except = %b, wb.valid = %b, expected 1 and 0",
                     $time, got_except, got_valid);
            abort_run();
        end
    endtask

    task automatic check_pc(input mips_pkg::word_t got_pc, input mips_pkg::word_t want_pc);
        if (got_pc !== want_pc) begin
            $display("** Error: time %0t: pc = %h, expected %h", $time, got_pc, want_pc);
            abort_run();
        end
    endtask

    task automatic load_trace();
        int               fd;
        int               n;
        logic [7:0]       tag;
        logic [8*128-1:0] rest;
        logic [63:0]      addr;
        logic [31:0]      word;
        int               reg_num;
        mips_pkg::word_t  value;
        fd = $fopen("dv/program_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file dv/program_trace.txt");
            abort_run();
        end else begin
            while (!$feof(fd)) begin
                n = $fscanf(fd, "%s", tag);
                if (n == 1) begin
                    if (tag == "I") begin
                        n = $fscanf(fd, "%h %h", addr, word);
                        imem[addr[11:2]] = word;
                    end else if (tag == "W") begin
                        n = $fscanf(fd, "%d %h", reg_num, value);
                        exp_addr.push_back(mips_pkg::reg_addr_t'(reg_num));
                        exp_data.push_back(value);
                    end else if (tag == "X") begin
                        except_expected = 1'b1;
                    end else if (tag == "/") begin
                        // skip the rest of a comment line
                        n = $fgets(rest, fd);
                    end else begin
                        $display("the trace file holds a record of unknown kind");
                        abort_run();
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic wait_for_wb(
        input mips_pkg::reg_addr_t want_addr,
        input mips_pkg::word_t     want_data,
        input int                  num
    );
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen) begin
            @(posedge clock);
            waited++;
            if (except) begin
                $display("an exception came while writeback %0d was still expected", num);
                abort_run();
            end else if (wb.valid) begin
                check_wb(wb.addr, wb.data, want_addr, want_data);
                seen = 1'b1;
            end else if (waited >= WAIT_CYCLES) begin
                $display("timed out after %0d cycles waiting for writeback %0d", waited, num);
                abort_run();
            end
        end
    endtask

    task automatic wait_for_except();
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen) begin
            @(posedge clock);
            waited++;
            // a writeback before the exception is a mismatch too
            if (except || wb.valid) begin
                check_except(except, wb.valid);
                seen = 1'b1;
            end else if (waited >= WAIT_CYCLES) begin
                $display("timed out after %0d cycles waiting for the exception", waited);
                abort_run();
            end
        end
    endtask

    initial begin
        arst_n          <= 1'b0;
        except_expected = 1'b0;
        seed            = 3;
        // unloaded slots hold an illegal opcode tagged with their index
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = 32'hF800_0000 | 32'(i);
        end
        load_trace();

        idle_cycles = $unsigned($random(seed)) % 8;
        repeat (RESET_CYCLES + idle_cycles) @(posedge clock);
        // pc sits at the reset vector while arst_n is low
        check_pc(pc, 64'h0);
        arst_n <= 1'b1;

        foreach (exp_addr[k]) begin
            wait_for_wb(exp_addr[k], exp_data[k], k);
        end
        if (except_expected) begin
            wait_for_except();
        end

        if (exp_addr.size() > 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("the trace gave no writeback to check");
            abort_run();
        end
    end
endmodule

// ==== dv/program_trace.txt ====
// I <byte address> <instruction>, W <register> <value>, X exception expected last
// alu and immediate ops
I 0000 20010005
I 0004 2002fffd
I 0008 00221820
I 000c 00412022
I 0010 00222824
I 0014 00223025
I 0018 00223826
I 001c 00224027
I 0020 0082482a
I 0024 0044502a
I 0028 304b00f0
I 002c 342c8000
I 0030 384dffff
I 0034 3c0e1234
I 0038 3c0f8001
// shifts
I 003c 00018100
I 0040 00028f02
I 0044 00049083
I 0048 000f9c03
// memory
I 004c 35d45678
I 0050 fc140010
I 0054 dc150010
I 0058 a0020013
I 005c 80160013
I 0060 80170011
I 0064 dc180010
// branches and jumps
I 0068 10230001
I 006c 20190001
I 0070 14230001
I 0074 20190063
I 0078 11400001
I 007c 2019004d
I 0080 201a0002
I 0084 14250001
I 0088 201a0003
I 008c 08000025
I 0090 201a0037
I 0094 201b00a4
I 0098 03600008
I 009c 201b0001
I 00a0 201b0002
I 00a4 201c0004
// timer interrupt setup, then spin until the handler sets r29
I 00a8 3c05ffff
I 00ac 20060001
I 00b0 40866000
I 00b4 20070064
I 00b8 fca7001c
I 00bc 13a0ffff
I 00c0 401e7000
I 00c4 f8000000
// handler
I 0200 201d0001
I 0204 401f6800
I 0208 fca0006c
I 020c 42000018
W 1 0000000000000005
W 2 fffffffffffffffd
W 3 0000000000000002
W 4 fffffffffffffff8
W 5 0000000000000005
W 6 fffffffffffffffd
W 7 fffffffffffffff8
W 8 0000000000000002
W 9 0000000000000001
W 10 0000000000000000
W 11 00000000000000f0
W 12 0000000000008005
W 13 ffffffffffff0002
W 14 0000000012340000
W 15 ffffffff80010000
W 16 0000000000000050
W 17 0000000fffffffff
W 18 fffffffffffffffe
W 19 ffffffffffff8001
W 20 0000000012345678
W 21 0000000012345678
W 22 fffffffffffffffd
W 23 0000000000000056
W 24 00000000fd345678
W 25 0000000000000001
W 26 0000000000000002
W 26 0000000000000003
W 27 00000000000000a4
W 28 0000000000000004
W 5 ffffffffffff0000
W 6 0000000000000001
W 7 0000000000000064
W 29 0000000000000001
W 31 0000000000008000
W 30 00000000000000bc
X

// ==== sources.f ====
+incdir+include
src/mips_pkg.sv
src/mips_decoder.sv
src/exec_unit.sv
src/regfile.sv
src/data_mem.sv
src/timer.sv
src/cp0.sv
src/full_machine.sv
dv/tb_full_machine.sv

// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --Mdir obj_dir
TOP      := tb_full_machine
FILELIST := sources.f
SIM      := obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(SIM)

clean:
	rm -rf obj_dir
